//--- rtl/rv_core.sv
module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h0
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0] imem_rdata,
  output logic [rv_pkg::xlen-1:0] dmem_addr,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  output logic                    dmem_we,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata
);

  // IF/ID
  logic [rv_pkg::xlen-1:0]       id_instr;
  logic [rv_pkg::xlen-1:0]       id_pc;
  logic                          id_valid;

  // ID/EX
  logic [rv_pkg::xlen-1:0]       ex_pc;
  logic [rv_pkg::xlen-1:0]       ex_rs1_data;
  logic [rv_pkg::xlen-1:0]       ex_rs2_data;
  logic [rv_pkg::xlen-1:0]       ex_imm;
  logic [rv_pkg::reg_addr_w-1:0] ex_rs1;
  logic [rv_pkg::reg_addr_w-1:0] ex_rs2;
  logic [rv_pkg::reg_addr_w-1:0] ex_rd;
  logic [rv_pkg::alu_op_w-1:0]   ex_alu_op;
  logic [1:0]                    ex_src_a;
  logic                          ex_src_b_imm;
  logic                          ex_is_branch;
  logic                          ex_branch_ne;
  logic                          ex_is_jal;
  logic                          ex_is_jalr;
  logic                          ex_mem_read;
  logic                          ex_mem_write;
  logic                          ex_reg_write;

  // Redirect from execute
  logic                          redirect;
  logic [rv_pkg::xlen-1:0]       redirect_pc;

  // EX/MEM
  logic [rv_pkg::xlen-1:0]       mem_result;
  logic [rv_pkg::xlen-1:0]       mem_store_data;
  logic [rv_pkg::reg_addr_w-1:0] mem_rd;
  logic                          mem_reg_write;
  logic                          mem_read;
  logic                          mem_write;

  // Memory stage result and MEM/WB
  logic [rv_pkg::xlen-1:0]       fwd_data;
  logic                          wb_we;
  logic [rv_pkg::reg_addr_w-1:0] wb_rd;
  logic [rv_pkg::xlen-1:0]       wb_data;

  rv_fetch #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk, .rst, .redirect, .redirect_pc,
    .imem_addr, .imem_rdata,
    .id_instr, .id_pc, .id_valid
  );

  rv_decode u_decode (
    .clk, .rst, .id_instr, .id_pc, .id_valid,
    .flush (redirect),  // Kills the instruction behind a taken branch
    .wb_we, .wb_rd, .wb_data,
    .ex_pc, .ex_rs1_data, .ex_rs2_data, .ex_imm,
    .ex_rs1, .ex_rs2, .ex_rd, .ex_alu_op, .ex_src_a, .ex_src_b_imm,
    .ex_is_branch, .ex_branch_ne, .ex_is_jal, .ex_is_jalr,
    .ex_mem_read, .ex_mem_write, .ex_reg_write
  );

  rv_execute u_execute (
    .clk, .rst,
    .ex_pc, .ex_rs1_data, .ex_rs2_data, .ex_imm,
    .ex_rs1, .ex_rs2, .ex_rd, .ex_alu_op, .ex_src_a, .ex_src_b_imm,
    .ex_is_branch, .ex_branch_ne, .ex_is_jal, .ex_is_jalr,
    .ex_mem_read, .ex_mem_write, .ex_reg_write,
    .fwd_data, .wb_we, .wb_rd, .wb_data,
    .redirect, .redirect_pc,
    .mem_result, .mem_store_data, .mem_rd, .mem_reg_write, .mem_read, .mem_write
  );

  rv_memory u_memory (
    .clk, .rst,
    .mem_result, .mem_store_data, .mem_rd, .mem_reg_write, .mem_read, .mem_write,
    .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata,
    .fwd_data, .wb_we, .wb_rd, .wb_data
  );

endmodule

//--- rtl/rv_decode.sv
module rv_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       id_instr,
  input  logic [rv_pkg::xlen-1:0]       id_pc,
  input  logic                          id_valid,
  input  logic                          flush,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  output logic [rv_pkg::xlen-1:0]       ex_pc,
  output logic [rv_pkg::xlen-1:0]       ex_rs1_data,
  output logic [rv_pkg::xlen-1:0]       ex_rs2_data,
  output logic [rv_pkg::xlen-1:0]       ex_imm,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  output logic [rv_pkg::alu_op_w-1:0]   ex_alu_op,
  output logic [1:0]                    ex_src_a,
  output logic                          ex_src_b_imm,
  output logic                          ex_is_branch,
  output logic                          ex_branch_ne,
  output logic                          ex_is_jal,
  output logic                          ex_is_jalr,
  output logic                          ex_mem_read,
  output logic                          ex_mem_write,
  output logic                          ex_reg_write
);

  rv_pkg::instr_u                instr;
  logic [rv_pkg::xlen-1:0]       imm;
  logic [rv_pkg::xlen-1:0]       rs1_data;
  logic [rv_pkg::xlen-1:0]       rs2_data;
  logic [rv_pkg::alu_op_w-1:0]   func_op;  // Op from funct3/funct7
  logic [rv_pkg::alu_op_w-1:0]   alu_op;
  logic [1:0]                    src_a;
  logic                          alt_op;
  logic                          src_b_imm;
  logic                          is_branch;
  logic                          is_jal;
  logic                          is_jalr;
  logic                          mem_read;
  logic                          mem_write;
  logic                          reg_write;
  logic                          take;

  assign instr = id_instr;
  assign take  = id_valid & ~flush;  // Else a bubble enters ID/EX

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (instr.r.rs1),
    .rs2      (instr.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_we),
    .rd       (wb_rd),
    .wdata    (wb_data)
  );

  // Immediate by format, I-type by default
  always_comb begin
    imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    case (instr.r.opcode)
      rv_pkg::op_store:
        imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      rv_pkg::op_branch:
        imm = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
               instr.b.imm_4_1, 1'b0};
      rv_pkg::op_lui, rv_pkg::op_auipc:
        imm = {instr.u.imm_31_12, 12'h000};
      rv_pkg::op_jal:
        imm = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
               instr.j.imm_10_1, 1'b0};
      default: ;
    endcase
  end

  // funct7[5] selects SUB only for R-type, SRA for both shift forms
  assign alt_op = instr.r.funct7[5] &
                  ((instr.r.opcode == rv_pkg::op_rtype) | (instr.r.funct3 == 3'b101));

  always_comb begin
    case (instr.r.funct3)
      3'b000:  func_op = alt_op ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  func_op = rv_pkg::alu_sll;
      3'b010:  func_op = rv_pkg::alu_slt;
      3'b011:  func_op = rv_pkg::alu_sltu;
      3'b100:  func_op = rv_pkg::alu_xor;
      3'b101:  func_op = alt_op ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  func_op = rv_pkg::alu_or;
      default: func_op = rv_pkg::alu_and;
    endcase
  end

  // Main control, defaults describe a NOP
  always_comb begin
    alu_op    = rv_pkg::alu_add;
    src_a     = rv_pkg::src_a_rs1;
    src_b_imm = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    case (instr.r.opcode)
      rv_pkg::op_rtype: begin
        reg_write = 1'b1;
        alu_op    = func_op;
      end
      rv_pkg::op_itype: begin
        reg_write = 1'b1;
        src_b_imm = 1'b1;
        alu_op    = func_op;
      end
      rv_pkg::op_load: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        src_b_imm = 1'b1;  // Address is rs1 + imm
      end
      rv_pkg::op_store: begin
        mem_write = 1'b1;
        src_b_imm = 1'b1;
      end
      rv_pkg::op_branch: is_branch = (instr.b.funct3[2:1] == 2'b00);  // BEQ/BNE only
      rv_pkg::op_lui: begin
        reg_write = 1'b1;
        src_a     = rv_pkg::src_a_zero;
        src_b_imm = 1'b1;
      end
      rv_pkg::op_auipc: begin
        reg_write = 1'b1;
        src_a     = rv_pkg::src_a_pc;
        src_b_imm = 1'b1;
      end
      rv_pkg::op_jal: begin
        reg_write = 1'b1;  // Link value comes from execute
        is_jal    = 1'b1;
      end
      rv_pkg::op_jalr: begin
        reg_write = 1'b1;
        is_jalr   = 1'b1;
        src_b_imm = 1'b1;  // ALU forms rs1 + imm for the target
      end
      default: ;
    endcase
  end

  // ID/EX enables and kinds
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex_is_branch <= 1'b0;
      ex_branch_ne <= 1'b0;
      ex_is_jal    <= 1'b0;
      ex_is_jalr   <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
    end else begin
      ex_is_branch <= take & is_branch;
      ex_branch_ne <= take & instr.b.funct3[0];
      ex_is_jal    <= take & is_jal;
      ex_is_jalr   <= take & is_jalr;
      ex_mem_read  <= take & mem_read;
      ex_mem_write <= take & mem_write;
      ex_reg_write <= take & reg_write;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    ex_pc        <= id_pc;
    ex_rs1_data  <= rs1_data;
    ex_rs2_data  <= rs2_data;
    ex_imm       <= imm;
    ex_rs1       <= instr.r.rs1;
    ex_rs2       <= instr.r.rs2;
    ex_rd        <= instr.r.rd;
    ex_alu_op    <= alu_op;
    ex_src_a     <= src_a;
    ex_src_b_imm <= src_b_imm;
  end

endmodule

//--- rtl/rv_execute.sv
module rv_execute (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       ex_pc,
  input  logic [rv_pkg::xlen-1:0]       ex_rs1_data,
  input  logic [rv_pkg::xlen-1:0]       ex_rs2_data,
  input  logic [rv_pkg::xlen-1:0]       ex_imm,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  input  logic [rv_pkg::alu_op_w-1:0]   ex_alu_op,
  input  logic [1:0]                    ex_src_a,
  input  logic                          ex_src_b_imm,
  input  logic                          ex_is_branch,
  input  logic                          ex_branch_ne,
  input  logic                          ex_is_jal,
  input  logic                          ex_is_jalr,
  input  logic                          ex_mem_read,
  input  logic                          ex_mem_write,
  input  logic                          ex_reg_write,
  input  logic [rv_pkg::xlen-1:0]       fwd_data,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          redirect,
  output logic [rv_pkg::xlen-1:0]       redirect_pc,
  output logic [rv_pkg::xlen-1:0]       mem_result,
  output logic [rv_pkg::xlen-1:0]       mem_store_data,
  output logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  output logic                          mem_reg_write,
  output logic                          mem_read,
  output logic                          mem_write
);

  logic [rv_pkg::xlen-1:0] rs1_val;  // Forwarded operands
  logic [rv_pkg::xlen-1:0] rs2_val;
  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] op_b;
  logic [rv_pkg::xlen-1:0] alu_y;
  logic [4:0]              shamt;
  logic                    taken;
  logic                    jump;

  // Youngest producer wins: memory stage, then writeback, then ID/EX copy
  function automatic logic [rv_pkg::xlen-1:0] forward(
    input logic [rv_pkg::reg_addr_w-1:0] rs,
    input logic [rv_pkg::xlen-1:0]       rf_val
  );
    if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
      return fwd_data;  // ALU result or load word, same cycle
    end
    if (wb_we && wb_rd != '0 && wb_rd == rs) begin
      return wb_data;
    end
    return rf_val;
  endfunction

  always_comb begin
    rs1_val = forward(ex_rs1, ex_rs1_data);
    rs2_val = forward(ex_rs2, ex_rs2_data);
  end

  always_comb begin
    case (ex_src_a)
      rv_pkg::src_a_pc:   op_a = ex_pc;
      rv_pkg::src_a_zero: op_a = '0;
      default:            op_a = rs1_val;
    endcase
  end

  assign op_b  = ex_src_b_imm ? ex_imm : rs2_val;
  assign shamt = op_b[4:0];  // Only low five bits shift

  always_comb begin
    case (ex_alu_op)
      rv_pkg::alu_sub:  alu_y = op_a - op_b;
      rv_pkg::alu_sll:  alu_y = op_a << shamt;
      rv_pkg::alu_slt:  alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu: alu_y = {31'b0, op_a < op_b};
      rv_pkg::alu_xor:  alu_y = op_a ^ op_b;
      rv_pkg::alu_srl:  alu_y = op_a >> shamt;
      rv_pkg::alu_sra:  alu_y = $signed(op_a) >>> shamt;
      rv_pkg::alu_or:   alu_y = op_a | op_b;
      rv_pkg::alu_and:  alu_y = op_a & op_b;
      default:          alu_y = op_a + op_b;
    endcase
  end

  // BEQ when equal, BNE when not
  assign taken = ex_is_branch & ((rs1_val == rs2_val) ^ ex_branch_ne);
  assign jump  = ex_is_jal | ex_is_jalr;

  assign redirect    = taken | jump;
  assign redirect_pc = ex_is_jalr ? {alu_y[31:1], 1'b0} : ex_pc + ex_imm;

  // EX/MEM control
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_reg_write <= 1'b0;
      mem_read      <= 1'b0;
      mem_write     <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_read      <= ex_mem_read;
      mem_write     <= ex_mem_write;
    end
  end

  // EX/MEM payload, jumps carry the link address
  always_ff @(posedge clk) begin
    mem_result     <= jump ? ex_pc + 32'd4 : alu_y;
    mem_store_data <= rs2_val;
    mem_rd         <= ex_rd;
  end

endmodule

//--- rtl/rv_fetch.sv
module rv_fetch #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = 32'h0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    redirect,
  input  logic [rv_pkg::xlen-1:0] redirect_pc,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0] imem_rdata,
  output logic [rv_pkg::xlen-1:0] id_instr,
  output logic [rv_pkg::xlen-1:0] id_pc,
  output logic                    id_valid
);

  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] pc_next;

  assign imem_addr = pc;  // Instruction port sees the PC directly

  // Target from execute wins over sequential fetch
  assign pc_next = redirect ? redirect_pc : pc + 32'd4;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= reset_pc;
      id_valid <= 1'b0;
    end else begin
      pc       <= pc_next;
      id_valid <= ~redirect;  // Word fetched under a redirect is wrong-path
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    id_pc    <= pc;
    id_instr <= redirect ? rv_pkg::nop_instr : imem_rdata;  // Squashed slot holds a NOP
  end

endmodule

//--- rtl/rv_memory.sv
module rv_memory (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::xlen-1:0]       mem_result,
  input  logic [rv_pkg::xlen-1:0]       mem_store_data,
  input  logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  input  logic                          mem_reg_write,
  input  logic                          mem_read,
  input  logic                          mem_write,
  output logic [rv_pkg::xlen-1:0]       dmem_addr,
  output logic [rv_pkg::xlen-1:0]       dmem_wdata,
  output logic                          dmem_we,
  input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
  output logic [rv_pkg::xlen-1:0]       fwd_data,
  output logic                          wb_we,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_data
);

  // Data port straight from EX/MEM, word accesses only
  assign dmem_addr  = mem_result;
  assign dmem_wdata = mem_store_data;
  assign dmem_we    = mem_write;

  // Load data arrives this cycle so execute can use it at once
  assign fwd_data = mem_read ? dmem_rdata : mem_result;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_we <= 1'b0;
    end else begin
      wb_we <= mem_reg_write;
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= fwd_data;
  end

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;  // Data and address width
  localparam int reg_addr_w = 5;   // Register index width
  localparam int alu_op_w   = 4;

  // addi x0,x0,0
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

  // Major opcodes
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // ALU operation codes
  localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll  = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt  = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor  = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl  = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra  = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or   = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and  = 4'd9;

  // Operand A sources
  localparam logic [1:0] src_a_rs1  = 2'd0;
  localparam logic [1:0] src_a_pc   = 2'd1;  // AUIPC
  localparam logic [1:0] src_a_zero = 2'd2;  // LUI

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, six field layouts
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

//--- rtl/rv_regfile.sv
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]       wdata
);

  logic [rv_pkg::xlen-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;  // Architectural state starts at zero
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // Reads see a same-cycle write, so decode needs no extra forward
  always_comb begin
    if (rs1 == '0) begin
      rs1_data = '0;
    end else if (we && rd == rs1) begin
      rs1_data = wdata;
    end else begin
      rs1_data = regs[rs1];
    end
    if (rs2 == '0) begin
      rs2_data = '0;
    end else if (we && rd == rs2) begin
      rs2_data = wdata;
    end else begin
      rs2_data = regs[rs2];
    end
  end

endmodule

//--- sim.f
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_core.sv
verif/tb_clock.sv
verif/rv_core_tb.sv

//--- verif/rv_core_tb.sv
module rv_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int              seed        = 52354;
  localparam int              mem_words   = 256;     // 1 KiB per memory
  localparam int              max_stores  = 256;
  localparam logic [31:0]     done_addr   = 32'h3f8;
  localparam logic [31:0]     poison_addr = 32'h3fc;  // Only wrong-path code writes here

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [mem_words];
  logic [31:0] dmem [mem_words];
  logic [31:0] ref_mem [mem_words];   // Reference model's own data memory
  string       instr_tag [mem_words];  // Test name per instruction slot
  logic [31:0] exp_addr [max_stores];
  logic [31:0] exp_data [max_stores];
  string       exp_name [max_stores];
  int          exp_count = 0;
  int          store_idx = 0;          // Next expected store
  int          prog_len  = 0;
  logic [31:0] st_addr   = 32'h200;    // Result area
  string       cur_test  = "";
  logic        built     = 1'b0;
  logic        done_seen = 1'b0;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  rv_core #(
    .reset_pc (32'h0)
  ) uut (
    .clk, .rst, .imem_addr, .imem_rdata, .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata
  );

  // Memory models, combinational read
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;  // Write on the edge
    end
  end

  // Bookkeeping at the edge that closes the store's cycle
  always @(posedge clk) begin
    if (!rst && dmem_we) begin
      store_idx <= store_idx + 1;
      done_seen <= (dmem_addr == done_addr);
    end
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    rv_pkg::instr_u w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: rv_pkg::op_rtype};
    return w;
  endfunction

  // I format, also used for loads and JALR
  function automatic logic [31:0] itype_word(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    rv_pkg::instr_u w;
    w.i = '{imm_11_0: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
    return w;
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    rv_pkg::instr_u w;
    w.s = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010, imm_4_0: imm[4:0],
            opcode: rv_pkg::op_store};
    return w;
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    rv_pkg::instr_u w;
    w.b = '{imm_12: off[12], imm_10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
            imm_4_1: off[4:1], imm_11: off[11], opcode: rv_pkg::op_branch};
    return w;
  endfunction

  function automatic logic [31:0] upper_word(input logic [6:0] op, input logic [4:0] rd,
                                             input logic [19:0] imm);
    rv_pkg::instr_u w;
    w.u = '{imm_31_12: imm, rd: rd, opcode: op};
    return w;
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    rv_pkg::instr_u w;
    w.j = '{imm_20: off[20], imm_10_1: off[10:1], imm_11: off[11], imm_19_12: off[19:12],
            rd: rd, opcode: rv_pkg::op_jal};
    return w;
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len]      = word;
    instr_tag[prog_len] = cur_test;
    prog_len++;
  endtask

  task automatic store_reg(input logic [4:0] rs);
    emit(store_word(rs, 5'd0, st_addr[11:0]));
    st_addr = st_addr + 32'd4;  // Each store site gets its own word
  endtask

  task automatic poison_slot();
    emit(store_word(5'd1, 5'd0, poison_addr[11:0]));
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    logic [31:0] a;
    logic [4:0]  rd;
    logic [4:0]  prev1;
    logic [4:0]  prev2;
    logic [11:0] imm;
    logic [6:0]  f7;
    cur_test = "alu_chain";
    for (int k = 1; k <= 4; k++) begin  // Random seeds in x1..x4
      rnd = $urandom;
      emit(upper_word(rv_pkg::op_lui, 5'(k), rnd[31:12]));
      emit(itype_word(rv_pkg::op_itype, 3'b000, 5'(k), 5'(k), rnd[11:0]));
    end
    prev1 = 5'd4;
    prev2 = 5'd3;
    for (int n = 0; n < 16; n++) begin
      rnd = $urandom;
      rd  = 5'(5 + n % 3);  // x5..x7 in turn
      if (rnd[3]) begin
        f7 = (rnd[4] && (rnd[2:0] == 3'b000 || rnd[2:0] == 3'b101)) ? 7'h20 : 7'h00;
        emit(rtype_word(f7, rnd[2:0], rd, prev1, prev2));  // Sources one and two back
      end else begin
        imm = rnd[31:20];
        if (rnd[2:0] == 3'b001) imm = {7'h00, rnd[9:5]};
        if (rnd[2:0] == 3'b101) imm = {rnd[4] ? 7'h20 : 7'h00, rnd[9:5]};
        emit(itype_word(rv_pkg::op_itype, rnd[2:0], rd, prev1, imm));
      end
      prev2 = prev1;
      prev1 = rd;
      if (n % 4 == 3) store_reg(rd);
    end
    cur_test = "lui_auipc";
    rnd = $urandom;
    emit(upper_word(rv_pkg::op_lui, 5'd8, rnd[19:0]));
    store_reg(5'd8);
    emit(upper_word(rv_pkg::op_auipc, 5'd9, rnd[31:12]));
    store_reg(5'd9);
    store_reg(5'd1);
    cur_test = "load_use";
    rnd = $urandom;
    emit(itype_word(rv_pkg::op_load, 3'b010, 5'd10, 5'd0, {4'h0, rnd[7:2], 2'b00}));
    emit(itype_word(rv_pkg::op_itype, 3'b000, 5'd11, 5'd10, rnd[31:20]));  // Uses load at once
    store_reg(5'd11);
    emit(itype_word(rv_pkg::op_load, 3'b010, 5'd12, 5'd0, {4'h0, rnd[15:10], 2'b00}));
    emit(rtype_word(7'h00, 3'b000, 5'd13, 5'd12, 5'd12));
    store_reg(5'd13);
    emit(itype_word(rv_pkg::op_load, 3'b010, 5'd14, 5'd0, {4'h0, rnd[23:18], 2'b00}));
    store_reg(5'd14);  // Loaded word straight into store data
    a = st_addr;
    store_reg(5'd5);
    emit(itype_word(rv_pkg::op_load, 3'b010, 5'd15, 5'd0, a[11:0]));  // Reads back the store
    store_reg(5'd15);
    cur_test = "branch";
    emit(branch_word(3'b000, 5'd3, 5'd3, 13'd12));  // BEQ taken
    poison_slot();
    poison_slot();
    store_reg(5'd3);
    emit(branch_word(3'b001, 5'd3, 5'd3, 13'd12));  // BNE not taken, slots run
    store_reg(5'd4);
    store_reg(5'd5);
    store_reg(5'd6);
    emit(itype_word(rv_pkg::op_itype, 3'b000, 5'd16, 5'd5, 12'd0));
    emit(branch_word(3'b000, 5'd16, 5'd5, 13'd12));  // Compare on a forwarded value
    poison_slot();
    poison_slot();
    store_reg(5'd16);
    emit(branch_word(3'b001, 5'd1, 5'd2, 13'd12));
    poison_slot();
    poison_slot();
    store_reg(5'd1);
    emit(branch_word(3'b000, 5'd1, 5'd2, 13'd12));
    store_reg(5'd2);
    store_reg(5'd7);
    store_reg(5'd8);
    emit(itype_word(rv_pkg::op_itype, 3'b000, 5'd17, 5'd0, 12'd3));
    emit(itype_word(rv_pkg::op_itype, 3'b000, 5'd17, 5'd17, 12'hfff));  // Loop head
    store_reg(5'd17);
    emit(branch_word(3'b001, 5'd17, 5'd0, -13'd8));  // Backward BNE
    store_reg(5'd17);
    cur_test = "jump";
    emit(jal_word(5'd18, 21'd12));
    poison_slot();
    poison_slot();
    store_reg(5'd18);
    emit(upper_word(rv_pkg::op_auipc, 5'd19, 20'h00000));
    emit(itype_word(rv_pkg::op_jalr, 3'b000, 5'd20, 5'd19, 12'd17));  // Odd target, bit 0 drops
    poison_slot();
    poison_slot();
    store_reg(5'd20);
    cur_test = "done";
    emit(store_word(5'd7, 5'd0, done_addr[11:0]));
    emit(jal_word(5'd0, 21'd0));  // Park here
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return sa >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Instruction-set model, fills the expected store list in program order
  task automatic run_reference();
    rv_pkg::instr_u w;
    logic [31:0]    x [32];
    logic [31:0]    pc;
    logic [31:0]    nxt;
    logic [31:0]    a;
    logic [31:0]    b;
    logic [31:0]    res;
    logic [31:0]    addr;
    logic [31:0]    i_imm;
    logic           alt;
    logic           wr;
    logic           fin;
    foreach (x[k]) x[k] = '0;
    pc  = '0;
    fin = 1'b0;
    for (int step = 0; step < 4000 && !fin; step++) begin
      w     = imem[pc[9:2]];
      a     = x[w.r.rs1];
      b     = x[w.r.rs2];
      i_imm = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
      alt   = w.r.funct7[5] && (w.r.opcode == rv_pkg::op_rtype || w.r.funct3 == 3'b101);
      nxt   = pc + 32'd4;
      wr    = 1'b1;
      res   = '0;
      case (w.r.opcode)
        rv_pkg::op_rtype: res = alu_ref(w.r.funct3, alt, a, b);
        rv_pkg::op_itype: res = alu_ref(w.r.funct3, alt, a, i_imm);
        rv_pkg::op_lui:   res = {w.u.imm_31_12, 12'h000};
        rv_pkg::op_auipc: res = pc + {w.u.imm_31_12, 12'h000};
        rv_pkg::op_load: begin
          addr = a + i_imm;
          res  = ref_mem[addr[9:2]];
        end
        rv_pkg::op_store: begin
          wr   = 1'b0;
          addr = a + {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
          ref_mem[addr[9:2]]  = b;
          exp_addr[exp_count] = addr;
          exp_data[exp_count] = b;
          exp_name[exp_count] = instr_tag[pc[9:2]];
          exp_count++;
          fin = (addr == done_addr);
        end
        rv_pkg::op_branch: begin
          wr = 1'b0;
          if ((a == b) != w.b.funct3[0]) begin  // funct3 bit 0 marks BNE
            nxt = pc + {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5,
                        w.b.imm_4_1, 1'b0};
          end
        end
        rv_pkg::op_jal: begin
          res = pc + 32'd4;
          nxt = pc + {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11,
                      w.j.imm_10_1, 1'b0};
        end
        rv_pkg::op_jalr: begin
          res = pc + 32'd4;
          nxt = (a + i_imm) & ~32'd1;
        end
        default: wr = 1'b0;
      endcase
      if (wr && w.r.rd != 5'd0) x[w.r.rd] = res;
      pc = nxt;
    end
    if (!fin) fail_now("Reference model never reached the done store");
  endtask

  // Data port writes in order against the expected list, mid-cycle where the port is stable
  store_addr_chk: assert property (@(negedge clk) disable iff (rst)
      dmem_we && store_idx < exp_count |-> dmem_addr == exp_addr[store_idx])
    else fail_now($sformatf("Mismatch %s store address expected %h actual %h",
                            exp_name[store_idx], exp_addr[store_idx], $sampled(dmem_addr)));

  store_data_chk: assert property (@(negedge clk) disable iff (rst)
      dmem_we && store_idx < exp_count |-> dmem_wdata == exp_data[store_idx])
    else fail_now($sformatf("Mismatch %s store data expected %h actual %h",
                            exp_name[store_idx], exp_data[store_idx], $sampled(dmem_wdata)));

  store_extra_chk: assert property (@(negedge clk) disable iff (rst)
      dmem_we |-> store_idx < exp_count)
    else fail_now($sformatf("Store to %h after the expected list ran out",
                            $sampled(dmem_addr)));

  // Quiet data port and reset PC through reset and one cycle past it
  reset_chk: assert property (@(posedge clk)
      rst || $past(rst) |-> !dmem_we && imem_addr == 32'h0)
    else fail_now("Data port write or PC other than 0 during reset");

  initial begin
    void'($urandom(seed));
    for (int k = 0; k < mem_words; k++) begin
      imem[k]    = rv_pkg::nop_instr;
      dmem[k]    = (k * 32'h0101_0101) ^ 32'hc3a5_5a3c;  // Differs for every word
      ref_mem[k] = dmem[k];
    end
    build_program();
    run_reference();
    built = 1'b1;
    wait (done_seen);
    @(posedge clk);  // Let the last store's checks run
    @(negedge clk);
    if (store_idx == exp_count) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_now($sformatf("Done store after %0d of %0d expected stores", store_idx, exp_count));
    end
  end

  // Watchdog scaled by program length
  initial begin
    wait (built);
    repeat ((prog_len + 50) * 10) @(posedge clk);
    fail_now("Timeout, the done store never reached the data port");
  end

endmodule

//--- verif/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Reset rises just after time zero so the asynchronous edge is seen
  initial begin
    rst = 1'b0;
    #1 rst = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;  // Released on a rising edge
  end

endmodule
